// ==== source/lsu_pkg.sv ====
// Load-store unit types
package lsu_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // Data word or byte address
  typedef logic [3:0]  byte_en_t;   // One write enable per byte lane
  typedef logic [4:0]  reg_addr_t;  // Destination register index
  typedef logic [3:0]  lsu_ctrl_t;  // Operation code

  //////////////////////////////////////////////////
  // Operation codes
  //////////////////////////////////////////////////

  // Field layout of lsu_ctrl_t
  //   bit 3     store
  //   bit 2     unsigned load
  //   bits 1:0  size, 0 byte, 1 halfword, 2 word

  // Loads, sign extended
  localparam lsu_ctrl_t LSU_LOAD_BYTE        = 4'b0000;
  localparam lsu_ctrl_t LSU_LOAD_HALF_WORD   = 4'b0001;
  localparam lsu_ctrl_t LSU_LOAD_WORD        = 4'b0010;

  // Loads, zero extended
  localparam lsu_ctrl_t LSU_LOAD_BYTE_U      = 4'b0100;
  localparam lsu_ctrl_t LSU_LOAD_HALF_WORD_U = 4'b0101;

  // Stores
  localparam lsu_ctrl_t LSU_STORE_BYTE       = 4'b1000;
  localparam lsu_ctrl_t LSU_STORE_HALF_WORD  = 4'b1001;
  localparam lsu_ctrl_t LSU_STORE_WORD       = 4'b1010;

  // Any other code is not issued by the decoder.
  // The unit treats an unknown load code as a word load
  // and an unknown store code as a store with no lanes.

endpackage

// ==== source/mem_bus_if.sv ====
// Data memory bus
`timescale 1ns/1ps

interface mem_bus_if;
  import lsu_pkg::*;

  // Request, driven by the load-store unit
  logic     stb;    // One complete access per high cycle
  byte_en_t we;     // Zero is a read, else lanes to write
  word_t    addr;   // Full byte address
  word_t    wdata;  // Store data already on its lanes

  // Response, one cycle after stb
  word_t    rdata;  // Old word on ack, zero on err
  logic     ack;    // Access done
  logic     err;    // Address beyond the RAM

  // Load-store unit side
  modport lsu (
    output stb, we, addr, wdata,
    input  rdata, ack, err
  );

  // RAM side
  modport ram (
    input  stb, we, addr, wdata,
    output rdata, ack, err
  );

endinterface

// ==== source/lsu_store_align.sv ====
// Store lane placement
`timescale 1ns/1ps

module lsu_store_align (
  input  lsu_pkg::lsu_ctrl_t ctrl_i,        // Operation code
  input  lsu_pkg::word_t     addr_i,        // Byte address of the access
  input  lsu_pkg::word_t     wdata_i,       // Register value, low bits used
  output lsu_pkg::word_t     lane_data_o,   // Data moved onto its lanes
  output lsu_pkg::byte_en_t  byte_en_o,     // Lanes to write
  output logic               misaligned_o   // Store not naturally aligned
);
  import lsu_pkg::*;

  logic [1:0] byte_off;  // Lane of the first byte

  assign byte_off = addr_i[1:0];

  //////////////////////////////////////////////////
  // Lane placement
  //////////////////////////////////////////////////

  always_comb begin
    // Loads and unknown codes write nothing
    lane_data_o  = '0;
    byte_en_o    = '0;
    misaligned_o = 1'b0;

    case (ctrl_i)
      LSU_STORE_BYTE: begin
        // Any offset is fine for a single byte
        lane_data_o = word_t'(wdata_i[7:0]) << {byte_off, 3'b000};
        byte_en_o   = 4'b0001 << byte_off;
      end

      LSU_STORE_HALF_WORD: begin
        lane_data_o  = word_t'(wdata_i[15:0]) << {byte_off[1], 4'b0000};
        byte_en_o    = byte_off[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
        misaligned_o = byte_off[0];                      // Odd address
      end

      LSU_STORE_WORD: begin
        lane_data_o  = wdata_i;   // Already in place
        byte_en_o    = 4'b1111;
        misaligned_o = |byte_off; // Must be a multiple of four
      end

      default: begin
        lane_data_o  = '0;
        byte_en_o    = '0;
        misaligned_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/lsu_load_align.sv ====
// Load lane selection
`timescale 1ns/1ps

module lsu_load_align (
  input  lsu_pkg::lsu_ctrl_t ctrl_i,      // Operation code of the load
  input  logic [1:0]         byte_off_i,  // Low address bits
  input  lsu_pkg::word_t     rdata_i,     // Raw word from memory
  output lsu_pkg::word_t     result_o     // Value for the register file
);
  import lsu_pkg::*;

  logic [7:0]  lane_byte;  // Addressed byte
  logic [15:0] lane_half;  // Addressed halfword

  //////////////////////////////////////////////////
  // Lane pick
  //////////////////////////////////////////////////

  assign lane_byte = rdata_i[8*byte_off_i +: 8];
  // Halfwords are aligned, so only bit 1 matters
  assign lane_half = byte_off_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  //////////////////////////////////////////////////
  // Extension
  //////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i)
      LSU_LOAD_BYTE: begin
        result_o = {{24{lane_byte[7]}}, lane_byte};   // Sign of bit 7
      end

      LSU_LOAD_BYTE_U: begin
        result_o = {24'b0, lane_byte};
      end

      LSU_LOAD_HALF_WORD: begin
        result_o = {{16{lane_half[15]}}, lane_half};  // Sign of bit 15
      end

      LSU_LOAD_HALF_WORD_U: begin
        result_o = {16'b0, lane_half};
      end

      // Word load passes the memory word through
      default: begin
        result_o = rdata_i;
      end
    endcase
  end

endmodule

// ==== source/lsu_core.sv ====
// Load-store pipeline
`timescale 1ns/1ps

module lsu_core (
  input  logic                clk_i,
  input  logic                rstn_i,

  // Request side
  input  logic                req_valid_i,
  input  lsu_pkg::lsu_ctrl_t  req_ctrl_i,
  input  lsu_pkg::word_t      req_addr_i,
  input  lsu_pkg::word_t      req_wdata_i,
  input  lsu_pkg::reg_addr_t  req_rd_i,

  // Data memory
  mem_bus_if.lsu              bus,

  // Register file writeback
  output logic                wb_valid_o,
  output lsu_pkg::word_t      wb_data_o,
  output lsu_pkg::reg_addr_t  wb_rd_o,

  // Exceptions for the trap unit
  output logic                misaligned_load_o,
  output logic                misaligned_store_o,
  output logic                bus_error_o,
  output lsu_pkg::word_t      exception_addr_o
);
  import lsu_pkg::*;

  // Request stage
  logic      req_valid_q;
  lsu_ctrl_t req_ctrl_q;
  word_t     req_addr_q;
  word_t     req_wdata_q;
  reg_addr_t req_rd_q;

  // Alignment results
  word_t     st_lane_data;
  byte_en_t  st_byte_en;
  logic      st_misaligned;  // Raw store align result before qualification
  logic      ld_fault;
  logic      st_fault;
  logic      req_go;         // Aligned access goes to the bus

  // Bus stage beside stb/we/addr/wdata
  lsu_ctrl_t bus_ctrl_q;
  reg_addr_t bus_rd_q;

  // Response stage lined up with ack/err
  logic      resp_valid_q;
  lsu_ctrl_t resp_ctrl_q;
  reg_addr_t resp_rd_q;
  word_t     resp_addr_q;
  word_t     ld_result;

  //////////////////////////////////////////////////
  // Request stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin  // Payload held while idle
      req_ctrl_q  <= req_ctrl_i;
      req_addr_q  <= req_addr_i;
      req_wdata_q <= req_wdata_i;
      req_rd_q    <= req_rd_i;
    end
  end

  lsu_store_align lsu_store_align_i (
    .ctrl_i       (req_ctrl_q),
    .addr_i       (req_addr_q),
    .wdata_i      (req_wdata_q),
    .lane_data_o  (st_lane_data),
    .byte_en_o    (st_byte_en),
    .misaligned_o (st_misaligned)
  );

  // Load alignment check
  always_comb begin
    ld_fault = 1'b0;
    if (req_valid_q) begin
      case (req_ctrl_q)
        LSU_LOAD_HALF_WORD, LSU_LOAD_HALF_WORD_U: ld_fault = req_addr_q[0];
        LSU_LOAD_WORD:                            ld_fault = |req_addr_q[1:0];
        default:                                  ld_fault = 1'b0;
      endcase
    end
  end

  assign st_fault = req_valid_q & st_misaligned;
  assign req_go   = req_valid_q & ~ld_fault & ~st_fault;  // No strobe on a fault

  //////////////////////////////////////////////////
  // Bus stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      bus.stb <= 1'b0;
      bus.we  <= '0;
    end else begin
      bus.stb <= req_go;
      bus.we  <= req_go ? st_byte_en : '0;  // Zero for every load
    end
  end

  always_ff @(posedge clk_i) begin
    bus.addr   <= req_addr_q;
    bus.wdata  <= st_lane_data;
    bus_ctrl_q <= req_ctrl_q;
    bus_rd_q   <= req_rd_q;
  end

  //////////////////////////////////////////////////
  // Response stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= bus.stb;  // RAM answers this one now
    end
  end

  always_ff @(posedge clk_i) begin
    resp_ctrl_q <= bus_ctrl_q;
    resp_rd_q   <= bus_rd_q;
    resp_addr_q <= bus.addr;
  end

  lsu_load_align lsu_load_align_i (
    .ctrl_i     (resp_ctrl_q),
    .byte_off_i (resp_addr_q[1:0]),
    .rdata_i    (bus.rdata),
    .result_o   (ld_result)
  );

  //////////////////////////////////////////////////
  // Writeback and exceptions
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid_o         <= 1'b0;
      bus_error_o        <= 1'b0;
      misaligned_load_o  <= 1'b0;
      misaligned_store_o <= 1'b0;
    end else begin
      wb_valid_o         <= resp_valid_q & bus.ack & ~resp_ctrl_q[3];  // Loads only
      bus_error_o        <= resp_valid_q & bus.err;                    // Loads and stores
      misaligned_load_o  <= ld_fault;
      misaligned_store_o <= st_fault;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_valid_q && bus.ack) begin
      wb_data_o <= ld_result;
      wb_rd_o   <= resp_rd_q;
    end
  end

  // Older access wins since its bus error reaches the trap unit first
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      exception_addr_o <= '0;
    end else if (resp_valid_q && bus.err) begin
      exception_addr_o <= resp_addr_q;
    end else if (ld_fault || st_fault) begin
      exception_addr_o <= req_addr_q;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // RAM gives one kind of answer per access
  a_wb_err_excl : assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(wb_valid_o && bus_error_o));

  // A faulting access never reaches the bus
  a_fault_no_stb : assert property (@(posedge clk_i) disable iff (!rstn_i)
    (ld_fault || st_fault) |=> !bus.stb);

  // Nor does the RAM answer it two edges on
  a_fault_no_answer : assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(ld_fault || st_fault, 2) |-> !(bus.ack || bus.err));

endmodule

// ==== source/data_ram.sv ====
// Byte-writable data RAM
`timescale 1ns/1ps

module data_ram #(
  parameter int unsigned RAM_DEPTH_WORDS = 256  // Power of two from 16 up
) (
  input  logic   clk_i,
  input  logic   rstn_i,
  mem_bus_if.ram bus
);
  import lsu_pkg::*;

  localparam int unsigned IDX_W = $clog2(RAM_DEPTH_WORDS);
  localparam int unsigned LANES = $bits(byte_en_t);

  word_t            mem_q [RAM_DEPTH_WORDS];
  logic [IDX_W-1:0] word_idx;  // Word inside the array
  logic             in_range;  // Upper address bits all zero

  assign word_idx = bus.addr[IDX_W+1:2];
  assign in_range = ~|bus.addr[31:IDX_W+2];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (bus.stb && in_range) begin
      for (int i = 0; i < LANES; i++) begin
        if (bus.we[i]) begin
          mem_q[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  // Old contents on a write and zero out of range
  always_ff @(posedge clk_i) begin
    if (bus.stb) begin
      bus.rdata <= in_range ? mem_q[word_idx] : '0;
    end
  end

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end else begin
      bus.ack <= bus.stb & in_range;
      bus.err <= bus.stb & ~in_range;  // Nothing written
    end
  end

  // Write lanes only come with a strobe
  a_we_with_stb : assert property (@(posedge clk_i) disable iff (!rstn_i)
    (bus.we != '0) |-> bus.stb);

  // A strobe carries a known address and lane mask
  a_stb_known : assert property (@(posedge clk_i) disable iff (!rstn_i)
    bus.stb |-> !$isunknown({bus.addr, bus.we}));

endmodule

// ==== source/lsu_top.sv ====
// Load-store subsystem top
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned RAM_DEPTH_WORDS = 256  // Data RAM size in words
) (
  input  logic               clk_i,
  input  logic               rstn_i,

  // Request from the decoder
  input  logic               req_valid_i,
  input  lsu_pkg::lsu_ctrl_t req_ctrl_i,
  input  lsu_pkg::word_t     req_addr_i,
  input  lsu_pkg::word_t     req_wdata_i,
  input  lsu_pkg::reg_addr_t req_rd_i,

  // Writeback to the register file
  output logic               wb_valid_o,
  output lsu_pkg::word_t     wb_data_o,
  output lsu_pkg::reg_addr_t wb_rd_o,

  // Exceptions
  output logic               misaligned_load_o,
  output logic               misaligned_store_o,
  output logic               bus_error_o,
  output lsu_pkg::word_t     exception_addr_o
);

  mem_bus_if bus_if ();  // Unit to RAM

  lsu_core lsu_core_i (
    .clk_i              (clk_i),
    .rstn_i             (rstn_i),
    .req_valid_i        (req_valid_i),
    .req_ctrl_i         (req_ctrl_i),
    .req_addr_i         (req_addr_i),
    .req_wdata_i        (req_wdata_i),
    .req_rd_i           (req_rd_i),
    .bus                (bus_if.lsu),
    .wb_valid_o         (wb_valid_o),
    .wb_data_o          (wb_data_o),
    .wb_rd_o            (wb_rd_o),
    .misaligned_load_o  (misaligned_load_o),
    .misaligned_store_o (misaligned_store_o),
    .bus_error_o        (bus_error_o),
    .exception_addr_o   (exception_addr_o)
  );

  data_ram #(
    .RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
  ) data_ram_i (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .bus    (bus_if.ram)
  );

endmodule

// ==== test/tb_lsu_top.sv ====
// Load-store subsystem testbench
`timescale 1ns/1ps

module tb_lsu_top;
  import lsu_pkg::*;

  localparam int unsigned DEPTH     = 256;                // RAM size in words
  localparam int unsigned ADDR_W    = $clog2(DEPTH) + 2;  // In-range byte address bits
  localparam int unsigned RESET_CYC = 16;
  localparam int unsigned N_RANDOM  = 400;

  // Expected response of one request
  typedef struct packed {
    logic [31:0] edge_n;    // Rising edge that sampled the request
    logic        mis_ld;
    logic        mis_st;
    logic        bus_err;
    logic        wb_valid;
    word_t       data;
    reg_addr_t   rd;
    word_t       addr;
  } resp_t;

  logic        clk;
  logic        rstn;
  logic        req_valid;
  lsu_ctrl_t   req_ctrl;
  word_t       req_addr;
  word_t       req_wdata;
  reg_addr_t   req_rd;
  logic        wb_valid;
  word_t       wb_data;
  reg_addr_t   wb_rd;
  logic        mis_ld;
  logic        mis_st;
  logic        bus_error;
  word_t       exc_addr;

  logic [7:0]  ref_mem [DEPTH*4];  // Byte model unknown until stored
  resp_t       flag_q [$];         // Misaligned flags due one edge after sampling
  resp_t       bus_q [$];          // Bus results due three edges after
  logic [31:0] lfsr_q = 32'd6;
  int unsigned cyc = 0;            // Rising edges so far
  int unsigned issued = 0;

  lsu_top #(
    .RAM_DEPTH_WORDS (DEPTH)
  ) lsu_top_i (
    .clk_i (clk), .rstn_i (rstn),
    .req_valid_i (req_valid), .req_ctrl_i (req_ctrl), .req_addr_i (req_addr),
    .req_wdata_i (req_wdata), .req_rd_i (req_rd),
    .wb_valid_o (wb_valid), .wb_data_o (wb_data), .wb_rd_o (wb_rd),
    .misaligned_load_o (mis_ld), .misaligned_store_o (mis_st),
    .bus_error_o (bus_error), .exception_addr_o (exc_addr)
  );

  always #5 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] res;
    logic        fb;
    res = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      res    = {res[30:0], fb};
    end
    return res;
  endfunction

  // Random destination register
  function automatic reg_addr_t rand_rd();
    return reg_addr_t'(rand_bits(5));
  endfunction

  // Fill value mixes every address bit
  function automatic word_t fill_word(input word_t addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'hA5F0_C381;
  endfunction

  function automatic lsu_ctrl_t pick_op(input logic [2:0] sel);
    case (sel)
      3'd0:    return LSU_LOAD_BYTE;
      3'd1:    return LSU_LOAD_HALF_WORD;
      3'd2:    return LSU_LOAD_WORD;
      3'd3:    return LSU_LOAD_BYTE_U;
      3'd4:    return LSU_LOAD_HALF_WORD_U;
      3'd5:    return LSU_STORE_BYTE;
      3'd6:    return LSU_STORE_HALF_WORD;
      default: return LSU_STORE_WORD;
    endcase
  endfunction

  // Byte-addressed reference model that updates ref_mem on stores
  function automatic resp_t model_access(input lsu_ctrl_t ctrl, input word_t addr,
                                         input word_t wdata, input reg_addr_t rd);
    resp_t      r;
    logic [1:0] size;
    logic       mis;
    logic [7:0] b;
    logic [15:0] h;
    r      = '0;
    r.rd   = rd;
    r.addr = addr;
    size   = ctrl[1:0];
    mis    = (size == 2'd1 && addr[0]) || (size == 2'd2 && addr[1:0] != 2'd0);
    if (mis) begin
      r.mis_st = ctrl[3];
      r.mis_ld = ~ctrl[3];
    end else if ((addr >> 2) >= DEPTH) begin
      r.bus_err = 1'b1;                    // Nothing written or returned
    end else if (ctrl[3]) begin
      ref_mem[addr] = wdata[7:0];
      if (size != 2'd0) ref_mem[addr+1] = wdata[15:8];
      if (size == 2'd2) begin
        ref_mem[addr+2] = wdata[23:16];
        ref_mem[addr+3] = wdata[31:24];
      end
    end else begin
      r.wb_valid = 1'b1;
      b = ref_mem[addr];
      h = {ref_mem[addr+1], ref_mem[addr]};  // Little endian
      case (size)
        2'd0:    r.data = ctrl[2] ? {24'h0, b} : {{24{b[7]}}, b};
        2'd1:    r.data = ctrl[2] ? {16'h0, h} : {{16{h[15]}}, h};
        default: r.data = {ref_mem[addr+3], ref_mem[addr+2], h};
      endcase
    end
    return r;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // Drive one request on the falling edge and record its expected response
  task automatic send(input lsu_ctrl_t ctrl, input word_t addr,
                      input word_t wdata, input reg_addr_t rd);
    resp_t r;
    r        = model_access(ctrl, addr, wdata, rd);
    r.edge_n = cyc + 1;
    if (r.mis_ld || r.mis_st) flag_q.push_back(r);
    else if (r.bus_err || r.wb_valid) bus_q.push_back(r);  // Good stores stay silent
    req_valid = 1'b1;
    req_ctrl  = ctrl;
    req_addr  = addr;
    req_wdata = wdata;
    req_rd    = rd;
    issued++;
    @(negedge clk);
  endtask

  task automatic idle(input int n);
    req_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    word_t     base;
    word_t     addr;
    lsu_ctrl_t op;
    clk       = 1'b0;
    rstn      = 1'b0;
    req_valid = 1'b0;
    req_ctrl  = '0;
    req_addr  = '0;
    req_wdata = '0;
    req_rd    = '0;
    repeat (RESET_CYC) @(negedge clk);
    rstn = 1'b1;
    idle(10);                                          // Quiet after reset
    for (int w = 0; w < DEPTH; w++) begin
      send(LSU_STORE_WORD, word_t'(4*w), fill_word(word_t'(4*w)), rand_rd());
    end
    for (int w = 0; w < 8; w++) begin                  // Every width and offset
      base = word_t'(4 * ((w * 29 + 3) % DEPTH));
      for (int off = 0; off < 4; off++) begin
        send(LSU_LOAD_BYTE, base + off, '0, rand_rd());
        send(LSU_LOAD_BYTE_U, base + off, '0, rand_rd());
        if (off % 2 == 0) begin
          send(LSU_LOAD_HALF_WORD, base + off, '0, rand_rd());
          send(LSU_LOAD_HALF_WORD_U, base + off, '0, rand_rd());
        end
      end
      send(LSU_LOAD_WORD, base, '0, rand_rd());
    end
    for (int j = 0; j < 4; j++) begin                  // Partial stores then read back
      send(LSU_STORE_BYTE, word_t'(4*j + j), rand_bits(32), rand_rd());
      send(LSU_STORE_HALF_WORD, word_t'(4*j + 2*(j % 2)), rand_bits(32), rand_rd());
      send(LSU_LOAD_WORD, word_t'(4*j), '0, rand_rd());
    end
    send(LSU_LOAD_HALF_WORD, 32'h41, '0, 5'd1);        // Misaligned group
    send(LSU_LOAD_WORD, 32'h46, '0, 5'd2);
    send(LSU_LOAD_HALF_WORD_U, 32'h43, '0, 5'd3);
    send(LSU_STORE_HALF_WORD, 32'h45, 32'hDEAD_BEEF, 5'd4);
    send(LSU_STORE_WORD, 32'h47, 32'h1234_5678, 5'd5);
    send(LSU_LOAD_WORD, 32'h44, '0, 5'd6);             // Memory unchanged
    send(LSU_LOAD_WORD, 32'h40, '0, 5'd7);
    send(LSU_LOAD_WORD, word_t'(DEPTH*4), '0, 5'd8);   // Beyond the RAM
    send(LSU_STORE_WORD, word_t'(DEPTH*4 + 8), 32'hCAFE_F00D, 5'd9);
    send(LSU_LOAD_BYTE_U, 32'hFFFF_FFF1, '0, 5'd10);
    send(LSU_STORE_BYTE, 32'h8000_0003, 32'h55, 5'd11);
    send(LSU_LOAD_WORD, word_t'(DEPTH*4 + 4), '0, 5'd12);
    idle(1);
    send(LSU_LOAD_HALF_WORD, 32'h11, '0, 5'd13);       // Flag on the bus-error edge
    for (int k = 0; k < N_RANDOM; k++) begin
      if (rand_bits(3) == 0) idle(1);
      op = pick_op(3'(rand_bits(3)));
      if (rand_bits(3) == 0) addr = word_t'(DEPTH*4) + rand_bits(10);
      else addr = rand_bits(ADDR_W);
      if (rand_bits(2) != 0) addr = addr & ~((32'd1 << op[1:0]) - 1);  // Mostly aligned
      send(op, addr, rand_bits(32), rand_rd());
    end
    idle(1);
    while (flag_q.size() != 0 || bus_q.size() != 0) @(negedge clk);
    idle(4);
    $display(">>> PASS");
    $finish;
  end

  //////////////////////////////////////////////////
  // Compare and watchdog
  //////////////////////////////////////////////////

  // Outputs checked every cycle after reset against the due entries
  initial begin : compare
    resp_t fr;
    resp_t br;
    word_t exp_addr;
    exp_addr = '0;
    @(posedge rstn);
    forever begin
      @(negedge clk);
      fr = '0;
      br = '0;
      if (flag_q.size() > 0 && flag_q[0].edge_n + 1 == cyc) fr = flag_q.pop_front();
      if (bus_q.size() > 0 && bus_q[0].edge_n + 3 == cyc) br = bus_q.pop_front();
      if (br.bus_err) exp_addr = br.addr;              // Bus error wins the edge
      else if (fr.mis_ld || fr.mis_st) exp_addr = fr.addr;
      check_flag("wb_valid_o", br.wb_valid, wb_valid);
      check_flag("bus_error_o", br.bus_err, bus_error);
      check_flag("misaligned_load_o", fr.mis_ld, mis_ld);
      check_flag("misaligned_store_o", fr.mis_st, mis_st);
      check_word("exception_addr_o", exp_addr, exc_addr);
      if (br.wb_valid) begin
        check_word("wb_data_o", br.data, wb_data);
        check_reg("wb_rd_o", br.rd, wb_rd);
      end
    end
  end

  // Twenty cycles per request on top of reset
  initial begin : watchdog
    @(negedge clk);
    while (cyc <= RESET_CYC + 20 * (issued + 1)) @(negedge clk);
    $display("timeout: run stalled at cycle %0d after %0d requests", cyc, issued);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== sim.f ====
source/lsu_pkg.sv
source/mem_bus_if.sv
source/lsu_store_align.sv
source/lsu_load_align.sv
source/lsu_core.sv
source/data_ram.sv
source/lsu_top.sv
test/tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu_subsystem

sources:
  - files:
      - source/lsu_pkg.sv
      - source/mem_bus_if.sv
      - source/lsu_store_align.sv
      - source/lsu_load_align.sv
      - source/lsu_core.sv
      - source/data_ram.sv
      - source/lsu_top.sv
  - target: test
    files:
      - test/tb_lsu_top.sv
